// ==== mips_isa_pkg.sv ====
package mips_isa_pkg;

    // Datapath and address width
    parameter int word_w = 32;

    // Register file index
    parameter int reg_w = 5;

    // Lane widths for sub-word accesses
    parameter int byte_w = 8;
    parameter int half_w = 16;

    // Memory access size as decoded from the load/store opcode
    typedef enum logic [1:0]
    {
        size_byte = 2'b00,
        size_half = 2'b01,
        size_word = 2'b10
    } size_t;

endpackage

// ==== pipe_pkg.sv ====
package pipe_pkg;

    // EX/MEM payload of one instruction leaving execute
    typedef struct packed
    {
        logic [mips_isa_pkg::word_w-1:0] pc8;
        logic [mips_isa_pkg::word_w-1:0] pc_branch;
        logic [mips_isa_pkg::word_w-1:0] alu;
        logic [mips_isa_pkg::word_w-1:0] store_data;
        // Already shifted left by 16
        logic [mips_isa_pkg::word_w-1:0] upper_imm;
        logic [mips_isa_pkg::reg_w-1:0]  rd;
        logic                            zero;
        // Memory stage control
        logic                            branch;
        logic                            neq_branch;
        logic                            mem_write;
        logic                            mem_read;
        mips_isa_pkg::size_t             mem_size;
        // Write-back control
        logic                            jal;
        logic                            mem_to_reg;
        logic                            reg_write;
        logic                            zero_extend;
        logic                            lui;
        logic                            halt;
    } ex_mem_t;

    // MEM/WB payload of one instruction leaving the memory stage
    typedef struct packed
    {
        logic [mips_isa_pkg::word_w-1:0] alu;
        // Whole word as read, lane picked at write-back
        logic [mips_isa_pkg::word_w-1:0] load_word;
        logic [mips_isa_pkg::word_w-1:0] pc8;
        logic [mips_isa_pkg::word_w-1:0] upper_imm;
        logic [1:0]                      byte_sel;
        logic [mips_isa_pkg::reg_w-1:0]  rd;
        mips_isa_pkg::size_t             load_size;
        logic                            zero_extend;
        logic                            mem_to_reg;
        logic                            jal;
        logic                            lui;
        logic                            reg_write;
        logic                            halt;
    } mem_wb_t;

endpackage

// ==== stage_latch.sv ====
`timescale 1ns/1ns

module stage_latch
#(
    parameter type payload_t = logic
)
(
    input  logic     i_clk,
    input  logic     i_rst_n,
    input  logic     i_step,
    input  logic     i_flush,
    input  payload_t i_data,
    output payload_t o_data
);

    payload_t data_q;

    // Flush wins over step, hold otherwise
    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            data_q <= '0;
        end
        else if (i_flush)
        begin
            data_q <= '0;
        end
        else if (i_step)
        begin
            data_q <= i_data;
        end
    end

    assign o_data = data_q;

endmodule

// ==== data_memory.sv ====
`timescale 1ns/1ns

module data_memory
#(
    parameter int DEPTH_WORDS = 256
)
(
    input  logic                            i_clk,
    input  logic                            i_we,
    input  logic [mips_isa_pkg::word_w-1:0] i_addr,
    input  mips_isa_pkg::size_t             i_size,
    input  logic [mips_isa_pkg::word_w-1:0] i_wdata,
    output logic [mips_isa_pkg::word_w-1:0] o_rdata
);

    localparam int lanes  = mips_isa_pkg::word_w / mips_isa_pkg::byte_w;
    localparam int addr_w = (DEPTH_WORDS > 1) ? $clog2(DEPTH_WORDS) : 1;

    logic [mips_isa_pkg::word_w-1:0] mem [DEPTH_WORDS];
    logic [addr_w-1:0]               word_idx;
    logic [lanes-1:0]                byte_en;
    logic [mips_isa_pkg::word_w-1:0] wdata_lanes;

    // Byte offset dropped, index wraps at the memory depth
    assign word_idx = addr_w'(i_addr[mips_isa_pkg::word_w-1:2] % DEPTH_WORDS);

    // Lane enables and replicated store data
    always_comb
    begin
        case (i_size)
            mips_isa_pkg::size_byte:
            begin
                byte_en     = 4'b0001 << i_addr[1:0];
                wdata_lanes = {lanes{i_wdata[mips_isa_pkg::byte_w-1:0]}};
            end
            mips_isa_pkg::size_half:
            begin
                byte_en     = i_addr[1] ? 4'b1100 : 4'b0011;
                wdata_lanes = {2{i_wdata[mips_isa_pkg::half_w-1:0]}};
            end
            mips_isa_pkg::size_word:
            begin
                byte_en     = 4'b1111;
                wdata_lanes = i_wdata;
            end
            default:
            begin
                // Unused size code writes nothing
                byte_en     = '0;
                wdata_lanes = i_wdata;
            end
        endcase
    end

    always_ff @(posedge i_clk)
    begin
        if (i_we)
        begin
            for (int i = 0; i < lanes; i++)
            begin
                if (byte_en[i])
                begin
                    mem[word_idx][i*mips_isa_pkg::byte_w +: mips_isa_pkg::byte_w] <=
                        wdata_lanes[i*mips_isa_pkg::byte_w +: mips_isa_pkg::byte_w];
                end
            end
        end
    end

    // Asynchronous whole-word read
    assign o_rdata = mem[word_idx];

endmodule

// ==== mem_stage.sv ====
`timescale 1ns/1ns

module mem_stage
#(
    parameter int DEPTH_WORDS = 256
)
(
    input  logic                            i_clk,
    input  logic                            i_step,
    input  pipe_pkg::ex_mem_t               i_ex_mem,
    output pipe_pkg::mem_wb_t               o_mem_wb,
    output logic                            o_pc_src,
    output logic [mips_isa_pkg::word_w-1:0] o_pc_target
);

    logic                            mem_we;
    logic [mips_isa_pkg::word_w-1:0] rdata;

    // No store while the pipeline is frozen
    assign mem_we = i_ex_mem.mem_write & i_step;

    data_memory
    #(
        .DEPTH_WORDS (DEPTH_WORDS)
    )
    dmem0
    (
        .i_clk   (i_clk),
        .i_we    (mem_we),
        .i_addr  (i_ex_mem.alu),
        .i_size  (i_ex_mem.mem_size),
        .i_wdata (i_ex_mem.store_data),
        .o_rdata (rdata)
    );

    // beq takes on zero, bne on nonzero
    assign o_pc_src    = (i_ex_mem.branch & i_ex_mem.zero) |
                         (i_ex_mem.neq_branch & ~i_ex_mem.zero);
    assign o_pc_target = i_ex_mem.pc_branch;

    always_comb
    begin
        o_mem_wb.alu         = i_ex_mem.alu;
        o_mem_wb.load_word   = i_ex_mem.mem_read ? rdata : '0;
        o_mem_wb.pc8         = i_ex_mem.pc8;
        o_mem_wb.upper_imm   = i_ex_mem.upper_imm;
        // Lane offset for the load extraction
        o_mem_wb.byte_sel    = i_ex_mem.alu[1:0];
        o_mem_wb.rd          = i_ex_mem.rd;
        o_mem_wb.load_size   = i_ex_mem.mem_size;
        o_mem_wb.zero_extend = i_ex_mem.zero_extend;
        o_mem_wb.mem_to_reg  = i_ex_mem.mem_to_reg;
        o_mem_wb.jal         = i_ex_mem.jal;
        o_mem_wb.lui         = i_ex_mem.lui;
        o_mem_wb.reg_write   = i_ex_mem.reg_write;
        o_mem_wb.halt        = i_ex_mem.halt;
    end

endmodule

// ==== writeback_select.sv ====
`timescale 1ns/1ns

module writeback_select
(
    input  pipe_pkg::mem_wb_t               i_mem_wb,
    output logic [mips_isa_pkg::word_w-1:0] o_wb_data,
    output logic [mips_isa_pkg::reg_w-1:0]  o_wb_rd,
    output logic                            o_wb_en,
    output logic                            o_halt
);

    localparam int byte_pad = mips_isa_pkg::word_w - mips_isa_pkg::byte_w;
    localparam int half_pad = mips_isa_pkg::word_w - mips_isa_pkg::half_w;

    logic [mips_isa_pkg::byte_w-1:0] load_byte;
    logic [mips_isa_pkg::half_w-1:0] load_half;
    logic                            byte_fill;
    logic                            half_fill;
    logic [mips_isa_pkg::word_w-1:0] load_value;

    // Little-endian lane extraction
    assign load_byte = i_mem_wb.load_word[i_mem_wb.byte_sel*mips_isa_pkg::byte_w +:
                                          mips_isa_pkg::byte_w];
    assign load_half = i_mem_wb.byte_sel[1] ?
                       i_mem_wb.load_word[mips_isa_pkg::word_w-1:mips_isa_pkg::half_w] :
                       i_mem_wb.load_word[mips_isa_pkg::half_w-1:0];

    // Sign bit unless lbu/lhu
    assign byte_fill = ~i_mem_wb.zero_extend & load_byte[mips_isa_pkg::byte_w-1];
    assign half_fill = ~i_mem_wb.zero_extend & load_half[mips_isa_pkg::half_w-1];

    always_comb
    begin
        case (i_mem_wb.load_size)
            mips_isa_pkg::size_byte: load_value = {{byte_pad{byte_fill}}, load_byte};
            mips_isa_pkg::size_half: load_value = {{half_pad{half_fill}}, load_half};
            default:                 load_value = i_mem_wb.load_word;
        endcase
    end

    // Link address first, then LUI, then load, then ALU
    always_comb
    begin
        if (i_mem_wb.jal)
        begin
            o_wb_data = i_mem_wb.pc8;
        end
        else if (i_mem_wb.lui)
        begin
            o_wb_data = i_mem_wb.upper_imm;
        end
        else if (i_mem_wb.mem_to_reg)
        begin
            o_wb_data = load_value;
        end
        else
        begin
            o_wb_data = i_mem_wb.alu;
        end
    end

    assign o_wb_rd = i_mem_wb.rd;
    assign o_wb_en = i_mem_wb.reg_write;
    assign o_halt  = i_mem_wb.halt;

endmodule

// ==== mem_wb_pipe.sv ====
`timescale 1ns/1ns

module mem_wb_pipe
#(
    parameter int DEPTH_WORDS = 256
)
(
    input  logic                            i_clk,
    input  logic                            i_rst_n,
    input  logic                            i_step,
    input  logic                            i_flush,
    input  logic [mips_isa_pkg::word_w-1:0] i_pc8,
    input  logic [mips_isa_pkg::word_w-1:0] i_pc_branch,
    input  logic [mips_isa_pkg::word_w-1:0] i_alu_result,
    input  logic                            i_alu_zero,
    input  logic [mips_isa_pkg::word_w-1:0] i_store_data,
    input  logic [mips_isa_pkg::word_w-1:0] i_upper_imm,
    input  logic [mips_isa_pkg::reg_w-1:0]  i_rd,
    input  logic                            i_branch,
    input  logic                            i_neq_branch,
    input  logic                            i_mem_write,
    input  logic                            i_mem_read,
    input  mips_isa_pkg::size_t             i_mem_size,
    input  logic                            i_jal,
    input  logic                            i_mem_to_reg,
    input  logic                            i_reg_write,
    input  logic                            i_zero_extend,
    input  logic                            i_lui,
    input  logic                            i_halt,
    output logic                            o_pc_src,
    output logic [mips_isa_pkg::word_w-1:0] o_pc_target,
    output logic [mips_isa_pkg::word_w-1:0] o_wb_data,
    output logic [mips_isa_pkg::reg_w-1:0]  o_wb_rd,
    output logic                            o_wb_en,
    output logic                            o_halt
);

    pipe_pkg::ex_mem_t ex_mem_d;
    pipe_pkg::ex_mem_t ex_mem_q;
    pipe_pkg::mem_wb_t mem_wb_d;
    pipe_pkg::mem_wb_t mem_wb_q;

    assign ex_mem_d = '{
        pc8:         i_pc8,
        pc_branch:   i_pc_branch,
        alu:         i_alu_result,
        store_data:  i_store_data,
        upper_imm:   i_upper_imm,
        rd:          i_rd,
        zero:        i_alu_zero,
        branch:      i_branch,
        neq_branch:  i_neq_branch,
        mem_write:   i_mem_write,
        mem_read:    i_mem_read,
        mem_size:    i_mem_size,
        jal:         i_jal,
        mem_to_reg:  i_mem_to_reg,
        reg_write:   i_reg_write,
        zero_extend: i_zero_extend,
        lui:         i_lui,
        halt:        i_halt
    };

    stage_latch #(.payload_t(pipe_pkg::ex_mem_t)) ex_mem_latch0
    (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_step  (i_step),
        .i_flush (i_flush),
        .i_data  (ex_mem_d),
        .o_data  (ex_mem_q)
    );

    mem_stage #(.DEPTH_WORDS(DEPTH_WORDS)) mem_stage0
    (
        .i_clk       (i_clk),
        .i_step      (i_step),
        .i_ex_mem    (ex_mem_q),
        .o_mem_wb    (mem_wb_d),
        .o_pc_src    (o_pc_src),
        .o_pc_target (o_pc_target)
    );

    // MEM/WB is never flushed
    stage_latch #(.payload_t(pipe_pkg::mem_wb_t)) mem_wb_latch0
    (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_step  (i_step),
        .i_flush (1'b0),
        .i_data  (mem_wb_d),
        .o_data  (mem_wb_q)
    );

    writeback_select wb_sel0
    (
        .i_mem_wb  (mem_wb_q),
        .o_wb_data (o_wb_data),
        .o_wb_rd   (o_wb_rd),
        .o_wb_en   (o_wb_en),
        .o_halt    (o_halt)
    );

endmodule

// ==== tb_clock_gen.sv ====
`timescale 1ns/1ns

module tb_clock_gen
#(
    parameter int period_ns    = 100,
    parameter int reset_cycles = 3
)
(
    output logic o_clk,
    output logic o_rst_n
);

    initial
    begin
        o_clk = 1'b0;
        forever #(period_ns / 2) o_clk = ~o_clk;
    end

    initial
    begin
        o_rst_n = 1'b0;
        repeat (reset_cycles) @(posedge o_clk);
        o_rst_n <= 1'b1;
    end

endmodule

// ==== mem_wb_pipe_props.sv ====
`timescale 1ns/1ns

module mem_wb_pipe_props
#(
    parameter int width = 1
)
(
    input logic             i_clk,
    input logic             i_rst_n,
    input logic             i_step,
    input logic             i_flush,
    input logic [width-1:0] i_out
);

    int fail_count = 0;

    // A flush clears the whole payload
    flush_clears: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_flush |=> (i_out == '0))
        else
        begin
            fail_count++;
            $error("latch output not zero after flush");
        end

    hold_when_idle: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (!i_step && !i_flush) |=> $stable(i_out))
        else
        begin
            fail_count++;
            $error("latch output changed while not stepping");
        end

    no_unknown: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !$isunknown(i_out))
        else
        begin
            fail_count++;
            $error("latch output holds X or Z bits");
        end

endmodule

bind stage_latch mem_wb_pipe_props #(.width($bits(o_data))) props0
(
    .i_clk   (i_clk),
    .i_rst_n (i_rst_n),
    .i_step  (i_step),
    .i_flush (i_flush),
    .i_out   (o_data)
);

// ==== mem_wb_pipe_tb.sv ====
`timescale 1ns/1ns

module mem_wb_pipe_tb;

    localparam int mem_depth   = 16;
    localparam int stim_cycles = 155;
    localparam int cycle_limit = 2 * stim_cycles + 20;

    logic              clk;
    logic              rst_n;
    logic              step;
    logic              flush;
    pipe_pkg::ex_mem_t drv;
    logic              pc_src;
    logic [31:0]       pc_target;
    logic [31:0]       wb_data;
    logic [4:0]        wb_rd;
    logic              wb_en;
    logic              halt;

    // Reference state of one EX/MEM slot plus expected write-back outputs
    logic [31:0]       model_mem [mem_depth];
    pipe_pkg::ex_mem_t model_ex;
    logic [31:0]       exp_wb_data;
    logic [4:0]        exp_wb_rd;
    logic              exp_wb_en;
    logic              exp_halt;
    logic [15:0]       lfsr_state;
    int                cycles = 0;
    int                error_count = 0;

    tb_clock_gen #(.period_ns(100), .reset_cycles(3)) clk_gen0
    (
        .o_clk   (clk),
        .o_rst_n (rst_n)
    );

    mem_wb_pipe #(.DEPTH_WORDS(mem_depth)) dut0
    (
        .i_clk (clk), .i_rst_n (rst_n), .i_step (step), .i_flush (flush),
        .i_pc8 (drv.pc8), .i_pc_branch (drv.pc_branch), .i_alu_result (drv.alu),
        .i_alu_zero (drv.zero), .i_store_data (drv.store_data),
        .i_upper_imm (drv.upper_imm), .i_rd (drv.rd), .i_branch (drv.branch),
        .i_neq_branch (drv.neq_branch), .i_mem_write (drv.mem_write),
        .i_mem_read (drv.mem_read), .i_mem_size (drv.mem_size), .i_jal (drv.jal),
        .i_mem_to_reg (drv.mem_to_reg), .i_reg_write (drv.reg_write),
        .i_zero_extend (drv.zero_extend), .i_lui (drv.lui), .i_halt (drv.halt),
        .o_pc_src (pc_src), .o_pc_target (pc_target), .o_wb_data (wb_data),
        .o_wb_rd (wb_rd), .o_wb_en (wb_en), .o_halt (halt)
    );

    // Fibonacci LFSR with taps 16 14 13 11
    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++)
        begin
            fb         = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
            lfsr_state = {lfsr_state[14:0], fb};
            r          = {r[30:0], fb};
        end
        return r;
    endfunction

    // Kinds 0 word store, 1 word load, 2 sub-word store, 3 sub-word load, 4 random control
    function automatic pipe_pkg::ex_mem_t rand_instr(int kind);
        pipe_pkg::ex_mem_t e;
        e             = '0;
        e.pc8         = rand_bits(32);
        e.pc_branch   = rand_bits(32);
        e.alu         = rand_bits(32);
        e.store_data  = rand_bits(32);
        e.upper_imm   = rand_bits(16) << 16;
        e.rd          = rand_bits(5);
        e.zero        = rand_bits(1);
        e.branch      = rand_bits(1);
        e.neq_branch  = rand_bits(1);
        e.zero_extend = rand_bits(1);
        e.mem_size    = mips_isa_pkg::size_word;
        if (kind == 2 || kind == 3)
            e.mem_size = rand_bits(1) ? mips_isa_pkg::size_half : mips_isa_pkg::size_byte;
        if (kind == 4)
        begin
            e.jal        = rand_bits(1);
            e.lui        = rand_bits(1);
            e.mem_to_reg = rand_bits(1);
            e.mem_read   = rand_bits(1);
            e.reg_write  = rand_bits(1);
            e.halt       = (rand_bits(3) == 0);
        end
        else
        begin
            e.mem_write  = (kind == 0 || kind == 2);
            e.mem_read   = (kind == 1 || kind == 3);
            e.mem_to_reg = e.mem_read;
            e.reg_write  = e.mem_read;
        end
        return e;
    endfunction

    function automatic logic ref_pc_src(pipe_pkg::ex_mem_t e);
        return (e.branch && e.zero) || (e.neq_branch && !e.zero);
    endfunction

    function automatic logic [31:0] ref_wb_data(pipe_pkg::ex_mem_t e, logic [31:0] word);
        logic [7:0]  lane8;
        logic [15:0] lane16;
        logic [31:0] ld;
        lane8  = word >> (8 * e.alu[1:0]);
        lane16 = e.alu[1] ? word[31:16] : word[15:0];
        if (e.mem_size == mips_isa_pkg::size_byte)
            ld = e.zero_extend ? 32'(lane8) : {{24{lane8[7]}}, lane8};
        else if (e.mem_size == mips_isa_pkg::size_half)
            ld = e.zero_extend ? 32'(lane16) : {{16{lane16[15]}}, lane16};
        else
            ld = word;
        if (e.jal)
            return e.pc8;
        if (e.lui)
            return e.upper_imm;
        return e.mem_to_reg ? ld : e.alu;
    endfunction

    // One clock edge of the reference pipeline
    function automatic void ref_edge(pipe_pkg::ex_mem_t in, logic s, logic f);
        int          idx;
        logic [31:0] word;
        idx  = (model_ex.alu >> 2) % mem_depth;
        word = model_ex.mem_read ? model_mem[idx] : '0;
        if (s)
        begin
            exp_wb_data = ref_wb_data(model_ex, word);
            exp_wb_rd   = model_ex.rd;
            exp_wb_en   = model_ex.reg_write;
            exp_halt    = model_ex.halt;
            if (model_ex.mem_write && model_ex.mem_size == mips_isa_pkg::size_byte)
                model_mem[idx][8 * model_ex.alu[1:0] +: 8] = model_ex.store_data[7:0];
            else if (model_ex.mem_write && model_ex.mem_size == mips_isa_pkg::size_half)
                model_mem[idx][16 * model_ex.alu[1] +: 16] = model_ex.store_data[15:0];
            else if (model_ex.mem_write)
                model_mem[idx] = model_ex.store_data;
        end
        if (f)
            model_ex = '0;
        else if (s)
            model_ex = in;
    endfunction

    task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
        if (got !== exp)
        begin
            error_count++;
            $display("[FAIL] %s: got 0x%08h, expected 0x%08h", name, got, exp);
            $display("tests failed");
            $fatal(1, "value mismatch on %s", name);
        end
    endtask

    task automatic issue(pipe_pkg::ex_mem_t e, logic s, logic f);
        @(posedge clk);
        drv   <= e;
        step  <= s;
        flush <= f;
    endtask

    always @(posedge clk)
    begin
        if (!rst_n)
        begin
            model_ex    = '0;
            exp_wb_data = '0;
            exp_wb_rd   = '0;
            exp_wb_en   = 1'b0;
            exp_halt    = 1'b0;
        end
        else
            ref_edge(drv, step, flush);
    end

    // Outputs settle well before the falling edge
    always @(negedge clk)
    begin
        if (rst_n)
        begin
            check_value("o_pc_src", 32'(pc_src), 32'(ref_pc_src(model_ex)));
            check_value("o_pc_target", pc_target, model_ex.pc_branch);
            check_value("o_wb_data", wb_data, exp_wb_data);
            check_value("o_wb_rd", 32'(wb_rd), 32'(exp_wb_rd));
            check_value("o_wb_en", 32'(wb_en), 32'(exp_wb_en));
            check_value("o_halt", 32'(halt), 32'(exp_halt));
        end
        if (dut0.ex_mem_latch0.props0.fail_count != 0 ||
            dut0.mem_wb_latch0.props0.fail_count != 0)
        begin
            $display("A pipeline latch assertion failed");
            $display("tests failed");
            $fatal(1, "assertion failure");
        end
    end

    always @(posedge clk)
    begin
        cycles++;
        if (cycles > cycle_limit)
        begin
            $display("Timeout: stimulus did not finish within %0d cycles", cycle_limit);
            $display("tests failed");
            $fatal(1, "timeout");
        end
    end

    initial
    begin
        pipe_pkg::ex_mem_t st;
        pipe_pkg::ex_mem_t ld;
        int                kind;
        lfsr_state = 16'd64515;
        step       = 1'b0;
        flush      = 1'b0;
        drv        = '0;
        while (rst_n !== 1'b1)
            @(posedge clk);
        // Fill every word first
        for (int i = 0; i < mem_depth; i++)
        begin
            st     = rand_instr(0);
            st.alu = 32'(i) << 2;
            issue(st, 1'b1, 1'b0);
        end
        for (int i = 0; i < 12; i++)
        begin
            st     = rand_instr(0);
            ld     = rand_instr(1);
            ld.alu = st.alu;
            issue(st, 1'b1, 1'b0);
            issue(ld, 1'b1, 1'b0);
        end
        // Sub-word store, then any lane of the same word
        for (int i = 0; i < 16; i++)
        begin
            st           = rand_instr(2);
            ld           = rand_instr(3);
            ld.alu[31:2] = st.alu[31:2];
            issue(st, 1'b1, 1'b0);
            issue(ld, 1'b1, 1'b0);
        end
        for (int i = 0; i < 24; i++)
            issue(rand_instr(4), 1'b1, 1'b0);
        // Flushed store must leave the old word in place
        for (int i = 0; i < 8; i++)
        begin
            st     = rand_instr(0);
            ld     = rand_instr(1);
            ld.alu = st.alu;
            issue(st, 1'b1, 1'b1);
            issue(ld, 1'b1, 1'b0);
        end
        for (int i = 0; i < 40; i++)
        begin
            kind = rand_bits(3) % 5;
            st   = rand_instr(kind);
            issue(st, rand_bits(2) != 0, 1'b0);
        end
        for (int i = 0; i < 3; i++)
            issue('0, 1'b1, 1'b0);
        @(posedge clk);
        @(negedge clk);
        #1;
        if (error_count == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

endmodule

// ==== mem_wb_pipe.f ====
mips_isa_pkg.sv
pipe_pkg.sv
stage_latch.sv
data_memory.sv
mem_stage.sv
writeback_select.sv
mem_wb_pipe.sv
tb_clock_gen.sv
mem_wb_pipe_props.sv
mem_wb_pipe_tb.sv

// ==== Bender.yml ====
package:
  name: mem_wb_pipe

sources:
  - mips_isa_pkg.sv
  - pipe_pkg.sv
  - stage_latch.sv
  - data_memory.sv
  - mem_stage.sv
  - writeback_select.sv
  - mem_wb_pipe.sv
  - target: simulation
    files:
      - tb_clock_gen.sv
      - mem_wb_pipe_props.sv
      - mem_wb_pipe_tb.sv
